//--- source/axi_mem_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, memory map and response codes for the memory subsystem
// imported by the array, both burst engines, the arbiter and the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package axi_mem_pkg;

   // payload widths
   typedef logic [31:0] addr_t;   // byte address
   typedef logic [63:0] data_t;   // one beat
   typedef logic [7:0]  strb_t;   // one bit per byte lane
   typedef logic [7:0]  len_t;    // beats minus one
   typedef logic [1:0]  resp_t;

   // memory window
   localparam addr_t       MEM_BASE  = 32'h8000_0000;
   localparam int unsigned MEM_WORDS = 1024;
   localparam int unsigned MEM_IDX_W = 10;

   typedef logic [MEM_IDX_W-1:0] word_idx_t;

   // response codes
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // read engine states
   typedef enum logic [1:0] {
      rd_idle,    // waiting for AR
      rd_fetch,   // array read in flight
      rd_send     // beat on R
   } read_state_t;

   // write engine states
   typedef enum logic [1:0] {
      wr_idle,    // waiting for AW
      wr_data,    // taking W beats
      wr_resp     // B pending
   } write_state_t;

endpackage

`default_nettype wire

//--- source/sram_array.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 1024 x 64 word store behind the AXI slave, one read and one write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module sram_array
   import axi_mem_pkg::*;
(
   input  logic      clk,
   // read port
   input  logic      rd_en,
   input  word_idx_t rd_idx,
   output data_t     rd_data,
   // write port
   input  logic      wr_en,
   input  word_idx_t wr_idx,
   input  data_t     wr_data,
   input  strb_t     wr_strb
);

   data_t mem [MEM_WORDS];

   // registered read, holds between enables
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_idx];   // old data on a same-word write
      end
   end

   // byte lanes are written independently
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wr_strb[b]) begin
               mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/axi_sram_read.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read burst engine of the SRAM slave, turns one AR into arlen+1 R beats
// each beat fetches its word first, so beats come every other cycle at best
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module axi_sram_read
   import axi_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // AR channel
   input  addr_t     araddr,
   input  len_t      arlen,
   input  logic      arvalid,
   output logic      arready,
   // R channel
   output data_t     rdata,
   output resp_t     rresp,
   output logic      rlast,
   output logic      rvalid,
   input  logic      rready,
   // array read port
   output logic      mem_rd_en,
   output word_idx_t mem_rd_idx,
   input  data_t     mem_rdata
);

   read_state_t state;

   addr_t base_addr;   // burst start
   len_t  burst_len;
   len_t  beat;        // current beat number

   addr_t beat_addr;
   addr_t beat_off;
   logic  beat_in;

   // INCR with 8-byte beats
   assign beat_addr = base_addr + (addr_t'(beat) << 3);
   assign beat_off  = beat_addr - MEM_BASE;
   // below the base wraps to a huge offset, so one compare covers both ends
   assign beat_in   = beat_off < addr_t'(MEM_WORDS * 8);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= rd_idle;
      end else begin
         case (state)
            rd_idle: begin
               if (arvalid) begin
                  state <= rd_fetch;
               end
            end
            rd_fetch: state <= rd_send;
            rd_send: begin
               if (rready) begin
                  state <= rlast ? rd_idle : rd_fetch;
               end
            end
            default: state <= rd_idle;
         endcase
      end
   end

   // burst bookkeeping
   always_ff @(posedge clk) begin
      if (state == rd_idle && arvalid) begin
         base_addr <= araddr;
         burst_len <= arlen;
         beat      <= '0;
      end else if (state == rd_send && rready && !rlast) begin
         beat <= beat + 1'b1;
      end
   end

   assign arready = (state == rd_idle);

   // skip the array for beats outside the window
   assign mem_rd_en  = (state == rd_fetch) && beat_in;
   assign mem_rd_idx = beat_off[MEM_IDX_W+2:3];

   // beat stays fixed from fetch to transfer, so beat_in holds too
   assign rvalid = (state == rd_send);
   assign rlast  = rvalid && (beat == burst_len);
   assign rdata  = beat_in ? mem_rdata : '0;
   assign rresp  = beat_in ? RESP_OKAY : RESP_SLVERR;

endmodule

`default_nettype wire

//--- source/axi_sram_write.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write burst engine of the SRAM slave, one AW, W beats up to wlast, one B
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module axi_sram_write
   import axi_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // AW channel
   input  addr_t     awaddr,
   input  len_t      awlen,
   input  logic      awvalid,
   output logic      awready,
   // W channel
   input  data_t     wdata,
   input  strb_t     wstrb,
   input  logic      wlast,
   input  logic      wvalid,
   output logic      wready,
   // B channel
   output resp_t     bresp,
   output logic      bvalid,
   input  logic      bready,
   // array write port
   output logic      mem_wr_en,
   output word_idx_t mem_wr_idx,
   output data_t     mem_wr_data,
   output strb_t     mem_wr_strb
);

   write_state_t state;

   addr_t w_addr;     // address of the next beat
   len_t  w_left;     // beats left after the current one
   logic  w_over;     // master went past awlen
   logic  w_err;      // sticky, some beat missed the window

   logic  w_xfer;
   addr_t w_off;
   logic  w_in;

   assign w_xfer = (state == wr_data) && wvalid;
   assign w_off  = w_addr - MEM_BASE;
   assign w_in   = w_off < addr_t'(MEM_WORDS * 8);   // wraps below the base

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= wr_idle;
      end else begin
         case (state)
            wr_idle: begin
               if (awvalid) begin
                  state <= wr_data;
               end
            end
            wr_data: begin
               if (wvalid && wlast) begin
                  state <= wr_resp;
               end
            end
            wr_resp: begin
               if (bready) begin
                  state <= wr_idle;
               end
            end
            default: state <= wr_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == wr_idle && awvalid) begin
         w_addr <= awaddr;
         w_left <= awlen;
         w_over <= 1'b0;
         w_err  <= 1'b0;
      end else if (w_xfer) begin
         w_addr <= w_addr + 32'd8;
         if (w_left == '0) begin
            w_over <= 1'b1;      // anything after this beat is dropped
         end else begin
            w_left <= w_left - 1'b1;
         end
         if (!w_in) begin
            w_err <= 1'b1;
         end
      end
   end

   assign awready = (state == wr_idle);
   assign wready  = (state == wr_data);
   assign bvalid  = (state == wr_resp);
   assign bresp   = w_err ? RESP_SLVERR : RESP_OKAY;

   assign mem_wr_en   = w_xfer && w_in && !w_over;
   assign mem_wr_idx  = w_off[MEM_IDX_W+2:3];
   assign mem_wr_data = wdata;
   assign mem_wr_strb = wstrb;

endmodule

`default_nettype wire

//--- source/axi_sram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 burst slave over the SRAM window, read and write run independently
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module axi_sram
   import axi_mem_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   // read address and data
   input  addr_t araddr,
   input  len_t  arlen,
   input  logic  arvalid,
   output logic  arready,
   output data_t rdata,
   output resp_t rresp,
   output logic  rlast,
   output logic  rvalid,
   input  logic  rready,
   // write address, data and response
   input  addr_t awaddr,
   input  len_t  awlen,
   input  logic  awvalid,
   output logic  awready,
   input  data_t wdata,
   input  strb_t wstrb,
   input  logic  wlast,
   input  logic  wvalid,
   output logic  wready,
   output resp_t bresp,
   output logic  bvalid,
   input  logic  bready
);

   logic      rd_en;
   word_idx_t rd_idx;
   data_t     rd_data;
   logic      wr_en;
   word_idx_t wr_idx;
   data_t     wr_data;
   strb_t     wr_strb;

   axi_sram_read u_read (
      .clk, .rst,
      .araddr, .arlen, .arvalid, .arready,
      .rdata, .rresp, .rlast, .rvalid, .rready,
      .mem_rd_en(rd_en), .mem_rd_idx(rd_idx), .mem_rdata(rd_data)
   );

   axi_sram_write u_write (
      .clk, .rst,
      .awaddr, .awlen, .awvalid, .awready,
      .wdata, .wstrb, .wlast, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .mem_wr_en(wr_en), .mem_wr_idx(wr_idx),
      .mem_wr_data(wr_data), .mem_wr_strb(wr_strb)
   );

   sram_array u_array (
      .clk,
      .rd_en, .rd_idx, .rd_data,
      .wr_en, .wr_idx, .wr_data, .wr_strb
   );

endmodule

`default_nettype wire

//--- source/axi_read_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-master read arbiter, round robin, grant held for a whole burst
// adds no latency, AR and R are muxed straight through
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module axi_read_arbiter
   import axi_mem_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   // master 0
   input  addr_t m0_araddr,
   input  len_t  m0_arlen,
   input  logic  m0_arvalid,
   output logic  m0_arready,
   output data_t m0_rdata,
   output resp_t m0_rresp,
   output logic  m0_rlast,
   output logic  m0_rvalid,
   input  logic  m0_rready,
   // master 1
   input  addr_t m1_araddr,
   input  len_t  m1_arlen,
   input  logic  m1_arvalid,
   output logic  m1_arready,
   output data_t m1_rdata,
   output resp_t m1_rresp,
   output logic  m1_rlast,
   output logic  m1_rvalid,
   input  logic  m1_rready,
   // toward the slave
   output addr_t s_araddr,
   output len_t  s_arlen,
   output logic  s_arvalid,
   input  logic  s_arready,
   input  data_t s_rdata,
   input  resp_t s_rresp,
   input  logic  s_rlast,
   input  logic  s_rvalid,
   output logic  s_rready
);

   logic busy;       // a burst owns the channel
   logic grant;      // 0 = m0, 1 = m1
   logic last_win;   // winner of the previous AR
   logic winner;
   logic sel;

   // m1 wins if alone, or if both ask and m0 had the last turn
   assign winner = m1_arvalid && (!m0_arvalid || !last_win);
   assign sel    = busy ? grant : winner;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         grant    <= 1'b0;
         last_win <= 1'b1;   // m0 first
      end else if (!busy) begin
         if (s_arvalid && s_arready) begin
            busy     <= 1'b1;
            grant    <= winner;
            last_win <= winner;
         end
      end else if (s_rvalid && s_rready && s_rlast) begin
         busy <= 1'b0;
      end
   end

   // AR path, only while idle
   assign s_araddr   = sel ? m1_araddr : m0_araddr;
   assign s_arlen    = sel ? m1_arlen : m0_arlen;
   assign s_arvalid  = !busy && (sel ? m1_arvalid : m0_arvalid);
   assign m0_arready = !busy && !sel && m0_arvalid && s_arready;
   assign m1_arready = !busy && sel && m1_arvalid && s_arready;

   // R path, payload shared, handshake steered by grant
   assign m0_rdata  = s_rdata;
   assign m0_rresp  = s_rresp;
   assign m0_rlast  = s_rlast;
   assign m1_rdata  = s_rdata;
   assign m1_rresp  = s_rresp;
   assign m1_rlast  = s_rlast;
   assign m0_rvalid = busy && !grant && s_rvalid;
   assign m1_rvalid = busy && grant && s_rvalid;
   assign s_rready  = busy && (grant ? m1_rready : m0_rready);

endmodule

`default_nettype wire

//--- source/mem_subsystem_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem, ifu and lsu share the slave read channel via the arbiter
// lsu writes go straight to the slave
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_subsystem_top
   import axi_mem_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   // instruction fetch reads
   input  addr_t ifu_araddr,
   input  len_t  ifu_arlen,
   input  logic  ifu_arvalid,
   output logic  ifu_arready,
   output data_t ifu_rdata,
   output resp_t ifu_rresp,
   output logic  ifu_rlast,
   output logic  ifu_rvalid,
   input  logic  ifu_rready,
   // load/store reads
   input  addr_t lsu_araddr,
   input  len_t  lsu_arlen,
   input  logic  lsu_arvalid,
   output logic  lsu_arready,
   output data_t lsu_rdata,
   output resp_t lsu_rresp,
   output logic  lsu_rlast,
   output logic  lsu_rvalid,
   input  logic  lsu_rready,
   // load/store writes
   input  addr_t lsu_awaddr,
   input  len_t  lsu_awlen,
   input  logic  lsu_awvalid,
   output logic  lsu_awready,
   input  data_t lsu_wdata,
   input  strb_t lsu_wstrb,
   input  logic  lsu_wlast,
   input  logic  lsu_wvalid,
   output logic  lsu_wready,
   output resp_t lsu_bresp,
   output logic  lsu_bvalid,
   input  logic  lsu_bready
);

   // arbitrated read channel
   addr_t s_araddr;
   len_t  s_arlen;
   logic  s_arvalid;
   logic  s_arready;
   data_t s_rdata;
   resp_t s_rresp;
   logic  s_rlast;
   logic  s_rvalid;
   logic  s_rready;

   axi_read_arbiter u_arb (
      .clk, .rst,
      .m0_araddr(ifu_araddr), .m0_arlen(ifu_arlen),
      .m0_arvalid(ifu_arvalid), .m0_arready(ifu_arready),
      .m0_rdata(ifu_rdata), .m0_rresp(ifu_rresp), .m0_rlast(ifu_rlast),
      .m0_rvalid(ifu_rvalid), .m0_rready(ifu_rready),
      .m1_araddr(lsu_araddr), .m1_arlen(lsu_arlen),
      .m1_arvalid(lsu_arvalid), .m1_arready(lsu_arready),
      .m1_rdata(lsu_rdata), .m1_rresp(lsu_rresp), .m1_rlast(lsu_rlast),
      .m1_rvalid(lsu_rvalid), .m1_rready(lsu_rready),
      .s_araddr, .s_arlen, .s_arvalid, .s_arready,
      .s_rdata, .s_rresp, .s_rlast, .s_rvalid, .s_rready
   );

   axi_sram u_sram (
      .clk, .rst,
      .araddr(s_araddr), .arlen(s_arlen), .arvalid(s_arvalid), .arready(s_arready),
      .rdata(s_rdata), .rresp(s_rresp), .rlast(s_rlast),
      .rvalid(s_rvalid), .rready(s_rready),
      .awaddr(lsu_awaddr), .awlen(lsu_awlen),
      .awvalid(lsu_awvalid), .awready(lsu_awready),
      .wdata(lsu_wdata), .wstrb(lsu_wstrb), .wlast(lsu_wlast),
      .wvalid(lsu_wvalid), .wready(lsu_wready),
      .bresp(lsu_bresp), .bvalid(lsu_bvalid), .bready(lsu_bready)
   );

endmodule

`default_nettype wire

//--- tb/mem_subsystem_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI handshake checks on the SRAM slave, bound into every axi_sram
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_subsystem_asserts
   import axi_mem_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input data_t rdata,
   input resp_t rresp,
   input logic  rlast,
   input logic  rvalid,
   input logic  rready,
   input logic  awready,
   input logic  wlast,
   input logic  wvalid,
   input logic  wready,
   input resp_t bresp,
   input logic  bvalid,
   input logic  bready
);

   // R beat holds under back-pressure
   r_stable: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
      else $error("R beat changed or dropped before rready");

   b_stable: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("B response changed or dropped before bready");

   rlast_valid: assert property (@(posedge clk) disable iff (rst) rlast |-> rvalid)
      else $error("rlast high without rvalid");

   // AW and W phases never overlap in the write engine
   aw_w_excl: assert property (@(posedge clk) disable iff (rst) !(awready && wready))
      else $error("awready and wready high together");

   b_after_wlast: assert property (@(posedge clk) disable iff (rst)
      $rose(bvalid) |-> $past(wvalid && wready && wlast))
      else $error("bvalid raised without a wlast transfer");

endmodule

bind axi_sram mem_subsystem_asserts u_asserts (.*);

`default_nettype wire

//--- tb/tb_mem_subsystem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for mem_subsystem_top, drives ifu and lsu bursts and checks
// every R and B transfer against a reference model of the SRAM window
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_mem_subsystem
   import axi_mem_pkg::*;
();

   // fill ~140, directed ~450, 20 random bursts at up to ~90 each, plus margin
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int FILL_WORDS     = 136;   // random bursts stay inside this

   logic clk;
   logic rst;

   // read ports, index 0 = ifu, 1 = lsu
   logic [1:0][31:0] araddr;
   logic [1:0][7:0]  arlen;
   logic [1:0]       arvalid, arready, rlast, rvalid, rready;
   logic [1:0][63:0] rdata;
   logic [1:0][1:0]  rresp;

   // lsu write port
   addr_t awaddr;
   len_t  awlen;
   logic  awvalid, awready;
   data_t wdata;
   strb_t wstrb;
   logic  wlast, wvalid, wready;
   resp_t bresp;
   logic  bvalid, bready;

   data_t model [MEM_WORDS];   // reference copy of the window
   string test_name;
   int    cycles = 0;
   int    seed;
   int    errors;

   // monitor state
   addr_t rd_addr [2];
   len_t  rd_len [2];
   int    rd_beat [2];
   logic  rd_busy [2];
   int    ar_cyc [2];
   logic  first_wait [2];   // first beat of the burst not seen yet
   int    owner;            // master holding the read channel
   int    prev_grant;
   logic  lat_check;
   addr_t wr_addr;
   int    wr_beat;
   logic  wr_err;
   logic  wr_busy;

   mem_subsystem_top uut (
      .clk, .rst,
      .ifu_araddr(araddr[0]), .ifu_arlen(arlen[0]),
      .ifu_arvalid(arvalid[0]), .ifu_arready(arready[0]),
      .ifu_rdata(rdata[0]), .ifu_rresp(rresp[0]), .ifu_rlast(rlast[0]),
      .ifu_rvalid(rvalid[0]), .ifu_rready(rready[0]),
      .lsu_araddr(araddr[1]), .lsu_arlen(arlen[1]),
      .lsu_arvalid(arvalid[1]), .lsu_arready(arready[1]),
      .lsu_rdata(rdata[1]), .lsu_rresp(rresp[1]), .lsu_rlast(rlast[1]),
      .lsu_rvalid(rvalid[1]), .lsu_rready(rready[1]),
      .lsu_awaddr(awaddr), .lsu_awlen(awlen),
      .lsu_awvalid(awvalid), .lsu_awready(awready),
      .lsu_wdata(wdata), .lsu_wstrb(wstrb), .lsu_wlast(wlast),
      .lsu_wvalid(wvalid), .lsu_wready(wready),
      .lsu_bresp(bresp), .lsu_bvalid(bvalid), .lsu_bready(bready)
   );

   always #5 clk = ~clk;

   function automatic logic in_window(addr_t a);
      return (a >= MEM_BASE) && (a < MEM_BASE + MEM_WORDS * 8);
   endfunction

   // expected {resp, data} of the beat at address a
   function automatic logic [65:0] ref_read(addr_t a);
      if (!in_window(a)) begin
         return {RESP_SLVERR, 64'h0};
      end
      return {RESP_OKAY, model[(a - MEM_BASE) >> 3]};
   endfunction

   function automatic data_t merge(data_t old, data_t d, strb_t s);
      data_t r;
      r = old;
      for (int b = 0; b < 8; b++) begin
         if (s[b]) begin
            r[b*8 +: 8] = d[b*8 +: 8];
         end
      end
      return r;
   endfunction

   function automatic data_t beat_data(addr_t a, logic [31:0] salt);
      return {a ^ salt, ~a};   // whole address in both halves
   endfunction

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic logic rand_bit();
      logic [31:0] r;
      r = rand_word();
      return r[0];
   endfunction

   // start words -8 .. FILL_WORDS-17, so up to 8 beats stay in filled words
   function automatic addr_t rand_addr();
      logic [31:0] w;
      w = rand_word() % (FILL_WORDS - 8);
      return MEM_BASE - 32'd64 + (w << 3);
   endfunction

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp) else begin
         $display("FAILED %s: %s expected %h, got %h", test_name, what, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond) else begin
         $display("error in %s: %s", test_name, msg);
         stop_on_error();
      end
   endtask

   // compare process, samples at negedge where all signals are settled
   always @(negedge clk) begin
      logic [65:0] exp;
      addr_t       a;
      if (!rst) begin
         for (int m = 0; m < 2; m++) begin
            if (arvalid[m] && arready[m]) begin
               // both waiting, so the previous winner steps aside
               check_true(!(arvalid[0] && arvalid[1] && prev_grant == m),
                          "previous winner granted again over a waiting master");
               prev_grant    = m;
               owner         = m;
               rd_addr[m]    = araddr[m];
               rd_len[m]     = arlen[m];
               rd_beat[m]    = 0;
               rd_busy[m]    = 1'b1;
               ar_cyc[m]     = cycles;
               first_wait[m] = 1'b1;
            end
            if (rvalid[m]) begin
               check_true(rd_busy[m] && owner == m, "rvalid on a master without the grant");
               if (first_wait[m]) begin
                  first_wait[m] = 1'b0;
                  if (lat_check) begin
                     check_value("read latency", 2, cycles - ar_cyc[m]);
                  end
               end
               if (rready[m]) begin
                  exp = ref_read(rd_addr[m] + addr_t'(rd_beat[m] * 8));
                  check_value("rdata", exp[63:0], rdata[m]);
                  check_value("rresp", exp[65:64], rresp[m]);
                  check_value("rlast", rd_beat[m] == rd_len[m], rlast[m]);
                  if (rlast[m]) begin
                     rd_busy[m] = 1'b0;
                  end else begin
                     rd_beat[m]++;
                  end
               end
            end
         end
         if (awvalid && awready) begin
            wr_addr = awaddr;
            wr_beat = 0;
            wr_err  = 1'b0;
            wr_busy = 1'b1;
         end
         if (wvalid && wready) begin
            a = wr_addr + addr_t'(wr_beat * 8);
            if (in_window(a)) begin
               model[(a - MEM_BASE) >> 3] = merge(model[(a - MEM_BASE) >> 3], wdata, wstrb);
            end else begin
               wr_err = 1'b1;   // beat dropped by the slave
            end
            wr_beat++;
         end
         if (bvalid && bready) begin
            check_value("bresp", wr_err ? RESP_SLVERR : RESP_OKAY, bresp);
            wr_busy = 1'b0;
         end
      end
   end

   // timeout
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_on_error();
      end
   end

   // one read burst on master m, returns one tick after the rlast edge
   task automatic read_burst(input int m, input addr_t a, input len_t l, input logic rnd);
      logic ar_hs;
      logic done;
      araddr[m]  = a;
      arlen[m]   = l;
      arvalid[m] = 1'b1;
      rready[m]  = rnd ? rand_bit() : 1'b1;
      do begin
         @(negedge clk);
         ar_hs = arvalid[m] && arready[m];
         done  = rvalid[m] && rready[m] && rlast[m];
         @(posedge clk);
         #1;
         if (ar_hs) begin
            arvalid[m] = 1'b0;
         end
         rready[m] = rnd ? rand_bit() : 1'b1;
      end while (!done);
   endtask

   // one lsu write burst, random strobes and wvalid gaps when rnd is set
   task automatic write_burst(input addr_t a, input len_t l, input strb_t s,
                              input logic [31:0] salt, input logic rnd);
      int   n;
      logic aw_hs, w_hs, b_hs;
      awaddr  = a;
      awlen   = l;
      awvalid = 1'b1;
      n       = 0;
      wdata   = beat_data(a, salt);
      wstrb   = rnd ? strb_t'(rand_word()) : s;
      wlast   = (l == 0);
      wvalid  = rnd ? rand_bit() : 1'b1;
      bready  = rnd ? rand_bit() : 1'b1;
      do begin
         @(negedge clk);
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         b_hs  = bvalid && bready;
         @(posedge clk);
         #1;
         if (aw_hs) begin
            awvalid = 1'b0;
         end
         if (w_hs) begin
            n++;
            wdata = beat_data(a + addr_t'(n * 8), salt);
            wstrb = rnd ? strb_t'(rand_word()) : s;
            wlast = (n == l);
         end
         if (n > l) begin
            wvalid = 1'b0;
         end else if (w_hs || !wvalid) begin
            wvalid = rnd ? rand_bit() : 1'b1;   // a pending beat holds
         end
         bready = rnd ? rand_bit() : 1'b1;
      end while (!b_hs);
   endtask

   initial begin
      int          k;
      logic [31:0] r;
      addr_t       a0, a1;
      clk        = 1'b0;
      rst        = 1'b1;
      seed       = 32'hb3fb_5beb;
      araddr     = '0;
      arlen      = '0;
      arvalid    = '0;
      rready     = '0;
      awaddr     = '0;
      awlen      = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      wlast      = 1'b0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      errors     = 0;
      owner      = -1;
      prev_grant = -1;
      lat_check  = 1'b0;
      wr_busy    = 1'b0;
      wr_err     = 1'b0;
      for (int m = 0; m < 2; m++) begin
         rd_busy[m]    = 1'b0;
         first_wait[m] = 1'b0;
      end
      test_name = "reset";
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      test_name = "fill";
      write_burst(MEM_BASE, len_t'(FILL_WORDS - 1), 8'hff, 32'h0, 1'b0);

      test_name = "write_read";
      write_burst(MEM_BASE + 32'h40, 8'd3, 8'hff, 32'h5a5a_0001, 1'b0);
      read_burst(1, MEM_BASE + 32'h40, 8'd3, 1'b0);

      test_name = "byte_strobe";
      write_burst(MEM_BASE + 32'h48, 8'd0, 8'b1010_0101, 32'hc3c3_0002, 1'b0);
      read_burst(1, MEM_BASE + 32'h40, 8'd2, 1'b0);

      // simultaneous requests, ifu asks twice so either master can hold the last turn
      test_name = "shared_read";
      for (k = 0; k < 4; k++) begin
         fork
            begin
               read_burst(0, MEM_BASE + 32'h100 + addr_t'(k * 32), 8'd3, 1'b0);
               read_burst(0, MEM_BASE + 32'h180 + addr_t'(k * 32), 8'd1, 1'b0);
            end
            read_burst(1, MEM_BASE + 32'h300, len_t'(k + 1), 1'b0);
         join
      end

      test_name = "out_of_range";
      read_burst(1, 32'h0000_0040, 8'd1, 1'b0);
      read_burst(0, MEM_BASE - 32'h10, 8'd3, 1'b0);   // crosses the base
      write_burst(32'h9000_0000, 8'd1, 8'hff, 32'hdead_0004, 1'b0);   // aliases word 0
      read_burst(1, MEM_BASE, 8'd1, 1'b0);
      write_burst(MEM_BASE + 32'h1ff0, 8'd3, 8'hff, 32'h0bad_0004, 1'b0);
      read_burst(0, MEM_BASE + 32'h1ff0, 8'd3, 1'b0);   // crosses the end

      test_name = "backpressure";
      for (k = 0; k < 20; k++) begin
         r  = rand_word();
         a0 = rand_addr();
         a1 = rand_addr();
         if (r[0]) begin
            write_burst(a0, len_t'(r[3:1]), 8'hff, rand_word(), 1'b1);
         end else begin
            fork
               read_burst(0, a0, len_t'(r[6:4]), 1'b1);
               read_burst(1, a1, len_t'(r[9:7]), 1'b1);
            join
         end
      end

      test_name = "read_latency";
      lat_check = 1'b1;
      read_burst(0, MEM_BASE + 32'h08, 8'd1, 1'b0);
      lat_check = 1'b0;

      repeat (5) @(posedge clk);
      assert (!rd_busy[0] && !rd_busy[1] && !wr_busy) else begin
         $display("a burst was still open at the end of the run");
         errors++;
      end
      if (errors == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         stop_on_error();
      end
   end

endmodule

`default_nettype wire

//--- files.f
source/axi_mem_pkg.sv
source/sram_array.sv
source/axi_sram_read.sv
source/axi_sram_write.sv
source/axi_sram.sv
source/axi_read_arbiter.sv
source/mem_subsystem_top.sv
tb/mem_subsystem_asserts.sv
tb/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - source/axi_mem_pkg.sv
  - source/sram_array.sv
  - source/axi_sram_read.sv
  - source/axi_sram_write.sv
  - source/axi_sram.sv
  - source/axi_read_arbiter.sv
  - source/mem_subsystem_top.sv
  - target: simulation
    files:
      - tb/mem_subsystem_asserts.sv
      - tb/tb_mem_subsystem.sv
